//--- src/prefix_char_match.sv
`timescale 1ns/1ps

`include "prefix_macros.svh"

module prefix_char_match
  import prefix_stream_pkg::*;
  import prefix_feature_pkg::*;
(
  input  ibc_beat_t  beat,
  input  feature_t   feature,
  output logic [3:0] match_cnt
);

  feature_match_t            exact_spec;
  feature_range_t            range_spec;
  logic [`PREFIX_NBYTES-1:0] hit;

  // both views of the spec word, the mode picks one below
  assign exact_spec = feature.spec.exact;
  assign range_spec = feature.spec.bounds;

  // per byte test, invalid bytes and disabled features never hit
  always_comb begin
    logic [7:0] c;
    logic       exact_hit;
    logic       range_hit;
    hit = '0;
    for (int i = 0; i < `PREFIX_NBYTES; i++) begin
      c = beat.tdata[8*i +: 8];
      exact_hit = ((c ^ exact_spec.value) & exact_spec.mask) == 8'h00;
      // lo above hi leaves both compares unable to hold together
      range_hit = (c >= range_spec.lo) && (c <= range_spec.hi);
      if (!feature.enable || !beat.vbytes[i]) begin
        hit[i] = 1'b0;
      end else if (feature.mode == MODE_EXACT) begin
        hit[i] = exact_hit;
      end else begin
        hit[i] = range_hit;
      end
    end
  end

  // population count of the hit bits, 0 to 8
  always_comb begin
    match_cnt = '0;
    for (int i = 0; i < `PREFIX_NBYTES; i++) begin
      match_cnt = match_cnt + {3'b000, hit[i]};
    end
  end

endmodule

//--- src/prefix_fe.sv
`timescale 1ns/1ps

`include "prefix_macros.svh"

module prefix_fe
  import prefix_stream_pkg::*;
  import prefix_feature_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 reset,
  input  feature_t                             fe_config [0:`N_PREFIX_FEATURES-1],
  input  ibc_beat_t                            ibc_beat,
  input  logic                                 ibc_ctr_reload,
  output feature_ctr_t                         feature_ctr [0:`N_PREFIX_FEATURES-1],
  output logic [(`N_PREFIX_FEATURE_CTR*8)-1:0] fe_ctr_1,
  output logic [(`N_PREFIX_FEATURE_CTR*8)-1:0] fe_ctr_2,
  output logic [(`N_PREFIX_FEATURE_CTR*8)-1:0] fe_ctr_3,
  output logic [(`N_PREFIX_FEATURE_CTR*8)-1:0] fe_ctr_4
);

  // counts gathered as [bank][slot]
  feature_ctr_t bank_ctr [`N_PREFIX_BLKS][`N_PREFIX_FEATURE_CTR];

  // one slot per instance, each slot carries one feature of every bank
  generate
    for (genvar k = 0; k < `N_PREFIX_FEATURE_CTR; k++) begin : fe_counters
      prefix_fe_counter u_prefix_fe_counter (
        .clk            (clk),
        .reset          (reset),
        .beat           (ibc_beat),
        .ibc_ctr_reload (ibc_ctr_reload),
        .fe_config_1    (fe_config[k]),
        .fe_config_2    (fe_config[k + `N_PREFIX_FEATURE_CTR]),
        .fe_config_3    (fe_config[k + 2*`N_PREFIX_FEATURE_CTR]),
        .fe_config_4    (fe_config[k + 3*`N_PREFIX_FEATURE_CTR]),
        .fe_counter_1   (bank_ctr[0][k]),
        .fe_counter_2   (bank_ctr[1][k]),
        .fe_counter_3   (bank_ctr[2][k]),
        .fe_counter_4   (bank_ctr[3][k])
      );
    end
  endgenerate

  // indexed view, feature k + 4b
  generate
    for (genvar b = 0; b < `N_PREFIX_BLKS; b++) begin : bank_route
      for (genvar k = 0; k < `N_PREFIX_FEATURE_CTR; k++) begin : slot_route
        assign feature_ctr[k + `N_PREFIX_FEATURE_CTR*b] = bank_ctr[b][k];
      end
    end
  endgenerate

  // packed per-bank view, slot k in byte k
  generate
    for (genvar k = 0; k < `N_PREFIX_FEATURE_CTR; k++) begin : pack_route
      assign fe_ctr_1[8*k +: 8] = bank_ctr[0][k];
      assign fe_ctr_2[8*k +: 8] = bank_ctr[1][k];
      assign fe_ctr_3[8*k +: 8] = bank_ctr[2][k];
      assign fe_ctr_4[8*k +: 8] = bank_ctr[3][k];
    end
  endgenerate

endmodule

//--- src/prefix_fe_counter.sv
`timescale 1ns/1ps

`include "prefix_macros.svh"

module prefix_fe_counter
  import prefix_stream_pkg::*;
  import prefix_feature_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  ibc_beat_t    beat,
  input  logic         ibc_ctr_reload,
  input  feature_t     fe_config_1,
  input  feature_t     fe_config_2,
  input  feature_t     fe_config_3,
  input  feature_t     fe_config_4,
  output feature_ctr_t fe_counter_1,
  output feature_ctr_t fe_counter_2,
  output feature_ctr_t fe_counter_3,
  output feature_ctr_t fe_counter_4
);

  feature_t     bank_config [`N_PREFIX_BLKS];
  feature_t     sel_config;
  logic [3:0]   match_cnt;
  feature_ctr_t counter [`N_PREFIX_BLKS];
  logic [8:0]   sum;
  feature_ctr_t next_cnt;

  assign bank_config[0] = fe_config_1;
  assign bank_config[1] = fe_config_2;
  assign bank_config[2] = fe_config_3;
  assign bank_config[3] = fe_config_4;

  // only the bank named by the beat is matched
  assign sel_config = bank_config[beat.blk_sel];

  prefix_char_match u_prefix_char_match (
    .beat      (beat),
    .feature   (sel_config),
    .match_cnt (match_cnt)
  );

  // saturating add, one spare bit catches the carry
  assign sum      = {1'b0, counter[beat.blk_sel]} + {5'b00000, match_cnt};
  assign next_cnt = sum[8] ? 8'hff : sum[7:0];

  // reload wins over a beat in the same cycle
  always_ff @(posedge clk) begin
    if (reset || ibc_ctr_reload) begin
      for (int b = 0; b < `N_PREFIX_BLKS; b++) begin
        counter[b] <= '0;
      end
    end else begin
      counter[beat.blk_sel] <= next_cnt;
    end
  end

  assign fe_counter_1 = counter[0];
  assign fe_counter_2 = counter[1];
  assign fe_counter_3 = counter[2];
  assign fe_counter_4 = counter[3];

endmodule

//--- src/prefix_feature_pkg.sv
package prefix_feature_pkg;

  // how the spec word of a feature is read
  typedef enum logic {
    MODE_EXACT = 1'b0,
    MODE_RANGE = 1'b1
  } feature_mode_e;

  // exact compare, only bits with mask set take part
  typedef struct packed {
    logic [7:0] value;
    logic [7:0] mask;
  } feature_match_t;

  // inclusive byte range, empty when lo is above hi
  typedef struct packed {
    logic [7:0] lo;
    logic [7:0] hi;
  } feature_range_t;

  // same 16 bits, decoded by the feature mode
  typedef union packed {
    feature_match_t exact;
    feature_range_t bounds;
  } feature_spec_u;

  typedef struct packed {
    logic          enable;
    feature_mode_e mode;
    feature_spec_u spec;
  } feature_t;

  // saturating per-feature byte count
  typedef logic [7:0] feature_ctr_t;

endpackage

//--- src/prefix_macros.svh
`ifndef PREFIX_MACROS_SVH
`define PREFIX_MACROS_SVH

// beat geometry
`define PREFIX_DWIDTH 64
`define PREFIX_NBYTES 8

// counter slots per bank
`define N_PREFIX_FEATURE_CTR 4

// banks, picked per beat by blk_sel
`define N_PREFIX_BLKS 4

// feature k + 4b lives in slot k, bank b
`define N_PREFIX_FEATURES (`N_PREFIX_FEATURE_CTR * `N_PREFIX_BLKS)

`endif

//--- src/prefix_stream_pkg.sv
`include "prefix_macros.svh"

package prefix_stream_pkg;

  // one input beat of the byte stream
  // byte i of tdata sits in bits 8i+7 down to 8i
  // bit i of vbytes validates byte i
  typedef struct packed {
    logic [`PREFIX_DWIDTH-1:0]         tdata;
    logic [`PREFIX_NBYTES-1:0]         vbytes;
    logic [$clog2(`N_PREFIX_BLKS)-1:0] blk_sel;
  } ibc_beat_t;

endpackage

//--- verif/prefix_fe_chk.sv
`timescale 1ns/1ps

`include "prefix_macros.svh"

module prefix_fe_chk
  import prefix_stream_pkg::*;
  import prefix_feature_pkg::*;
(
  input logic         clk,
  input logic         reset,
  input ibc_beat_t    ibc_beat,
  input logic         ibc_ctr_reload,
  input feature_ctr_t feature_ctr [0:`N_PREFIX_FEATURES-1]
);

  // failed assertions so far
  int assert_failures = 0;

  generate
    for (genvar f = 0; f < `N_PREFIX_FEATURES; f++) begin : per_feature
      localparam int BANK = f / `N_PREFIX_FEATURE_CTR;

      reload_clears: assert property (@(posedge clk) disable iff (reset)
        ibc_ctr_reload |=> feature_ctr[f] == '0)
        else begin
          $error("feature %0d not zero after reload", f);
          assert_failures++;
        end

      // counts only move up between clears
      no_decrease: assert property (@(posedge clk) disable iff (reset)
        !ibc_ctr_reload |=> feature_ctr[f] >= $past(feature_ctr[f]))
        else begin
          $error("feature %0d count went down", f);
          assert_failures++;
        end

      other_bank_holds: assert property (@(posedge clk) disable iff (reset)
        (!ibc_ctr_reload && ibc_beat.blk_sel != BANK) |=> $stable(feature_ctr[f]))
        else begin
          $error("feature %0d changed while bank %0d not selected", f, BANK);
          assert_failures++;
        end
    end
  endgenerate

endmodule

bind prefix_fe prefix_fe_chk u_prefix_fe_chk (
  .clk            (clk),
  .reset          (reset),
  .ibc_beat       (ibc_beat),
  .ibc_ctr_reload (ibc_ctr_reload),
  .feature_ctr    (feature_ctr)
);

//--- verif/prefix_fe_tb.sv
`timescale 1ns/1ps

`include "prefix_macros.svh"

module prefix_fe_tb
  import prefix_stream_pkg::*;
  import prefix_feature_pkg::*;
();

  localparam int N_EXACT  = 12;
  localparam int N_RANGE  = 8;
  localparam int N_RANDOM = 200;
  localparam int N_SAT    = 48;
  localparam int N_RELOAD = 17;
  localparam int TOTAL_BEATS = N_EXACT + N_RANGE + N_RANDOM + N_SAT + N_RELOAD + 8;

  logic         clk;
  logic         reset;
  feature_t     fe_config [0:`N_PREFIX_FEATURES-1];
  ibc_beat_t    ibc_beat;
  logic         ibc_ctr_reload;
  feature_ctr_t feature_ctr [0:`N_PREFIX_FEATURES-1];
  logic [31:0]  fe_ctr_1, fe_ctr_2, fe_ctr_3, fe_ctr_4;
  logic [31:0]  packed_ctr [`N_PREFIX_BLKS];

  feature_ctr_t model [0:`N_PREFIX_FEATURES-1];
  logic [31:0]  lfsr_state = 32'h1bacd14c;
  string        test_name = "reset";
  int           errors = 0;

  prefix_fe u_dut (
    .clk            (clk),
    .reset          (reset),
    .fe_config      (fe_config),
    .ibc_beat       (ibc_beat),
    .ibc_ctr_reload (ibc_ctr_reload),
    .feature_ctr    (feature_ctr),
    .fe_ctr_1       (fe_ctr_1),
    .fe_ctr_2       (fe_ctr_2),
    .fe_ctr_3       (fe_ctr_3),
    .fe_ctr_4       (fe_ctr_4)
  );

  assign packed_ctr[0] = fe_ctr_1;
  assign packed_ctr[1] = fe_ctr_2;
  assign packed_ctr[2] = fe_ctr_3;
  assign packed_ctr[3] = fe_ctr_4;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] next_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic feature_t make_exact(input logic en, input logic [7:0] v,
                                          input logic [7:0] m);
    feature_t f;
    f.enable = en;
    f.mode = MODE_EXACT;
    f.spec.exact.value = v;
    f.spec.exact.mask = m;
    return f;
  endfunction

  function automatic feature_t make_range(input logic en, input logic [7:0] lo,
                                          input logic [7:0] hi);
    feature_t f;
    f.enable = en;
    f.mode = MODE_RANGE;
    f.spec.bounds.lo = lo;
    f.spec.bounds.hi = hi;
    return f;
  endfunction

  // expected number of valid bytes of a beat that satisfy one feature
  function automatic int ref_count(input ibc_beat_t beat, input feature_t f);
    logic [7:0] c;
    int         n;
    n = 0;
    for (int i = 0; i < `PREFIX_NBYTES; i++) begin
      c = beat.tdata[8*i +: 8];
      if (f.enable && beat.vbytes[i]) begin
        if (f.mode == MODE_EXACT) begin
          if ((c & f.spec.exact.mask) == (f.spec.exact.value & f.spec.exact.mask)) n++;
        end else if (c >= f.spec.bounds.lo && c <= f.spec.bounds.hi) begin
          n++;
        end
      end
    end
    return n;
  endfunction

  // model update at the edge, then compare once the DUT has settled
  always @(posedge clk) begin : compare
    int          idx;
    int          sum;
    logic [31:0] exp_vec;
    if (reset || ibc_ctr_reload) begin
      for (int f = 0; f < `N_PREFIX_FEATURES; f++) model[f] = '0;
    end else begin
      for (int k = 0; k < `N_PREFIX_FEATURE_CTR; k++) begin
        idx = k + `N_PREFIX_FEATURE_CTR * ibc_beat.blk_sel;
        sum = model[idx] + ref_count(ibc_beat, fe_config[idx]);
        model[idx] = (sum > 255) ? 8'hff : sum[7:0];
      end
    end
    #1;
    for (int f = 0; f < `N_PREFIX_FEATURES; f++) begin
      if (feature_ctr[f] !== model[f]) begin
        $display("Fail %s feature_ctr[%0d] expected %0d actual %0d",
                 test_name, f, model[f], feature_ctr[f]);
        errors++;
      end
    end
    for (int b = 0; b < `N_PREFIX_BLKS; b++) begin
      exp_vec = {model[4*b+3], model[4*b+2], model[4*b+1], model[4*b]};
      if (packed_ctr[b] !== exp_vec) begin
        $display("Fail %s fe_ctr_%0d expected %h actual %h",
                 test_name, b + 1, exp_vec, packed_ctr[b]);
        errors++;
      end
    end
  end

  task automatic drive_beat(input logic [63:0] data, input logic [7:0] vb,
                            input logic [1:0] sel);
    ibc_beat.tdata = data;
    ibc_beat.vbytes = vb;
    ibc_beat.blk_sel = sel;
    @(negedge clk);
  endtask

  // sel below zero picks a random bank per beat
  task automatic random_beats(input int n, input int sel);
    logic [63:0] d;
    logic [7:0]  vb;
    logic [1:0]  s;
    for (int i = 0; i < n; i++) begin
      d = next_bits(64);
      vb = next_bits(8);
      s = (sel < 0) ? next_bits(2) : sel[1:0];
      drive_beat(d, vb, s);
    end
  endtask

  initial begin : watchdog
    #((8 + TOTAL_BEATS + 20) * 10);
    $display("run did not finish in time, stopped by the watchdog");
    $display("TB FAILED");
    $finish;
  end

  initial begin : stimulus
    reset = 1'b1;
    ibc_ctr_reload = 1'b0;
    ibc_beat = '0;
    fe_config[0]  = make_exact(1'b1, 8'h41, 8'hff);
    fe_config[1]  = make_exact(1'b1, 8'h40, 8'hf0);
    fe_config[2]  = make_exact(1'b1, 8'h01, 8'h01);
    fe_config[3]  = make_exact(1'b1, 8'h00, 8'h80);
    fe_config[4]  = make_range(1'b1, 8'h30, 8'h39);
    fe_config[5]  = make_range(1'b1, 8'h61, 8'h7a);
    // empty range
    fe_config[6]  = make_range(1'b1, 8'h80, 8'h40);
    fe_config[7]  = make_range(1'b1, 8'h55, 8'h55);
    fe_config[8]  = make_exact(1'b0, 8'h00, 8'h00);
    fe_config[9]  = make_range(1'b0, 8'h00, 8'hff);
    fe_config[10] = make_exact(1'b1, 8'h00, 8'h00);
    fe_config[11] = make_range(1'b1, 8'h00, 8'h7f);
    fe_config[12] = make_exact(1'b1, 8'h00, 8'h00);
    fe_config[13] = make_range(1'b1, 8'h00, 8'hff);
    fe_config[14] = make_exact(1'b1, 8'haa, 8'hff);
    fe_config[15] = make_range(1'b1, 8'hc0, 8'hff);
    repeat (8) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    test_name = "exact";
    drive_beat(64'h4142_4041_0130_7f80, 8'hff, 2'd0);
    drive_beat(64'h4142_4041_0130_7f80, 8'h0f, 2'd0);
    drive_beat(64'h4141_4141_4141_4141, 8'h00, 2'd0);
    drive_beat(64'h4f41_0203_8081_4e41, 8'ha6, 2'd0);
    random_beats(N_EXACT - 4, 0);

    test_name = "range";
    drive_beat(64'h3039_2f3a_6160_7a7b, 8'hff, 2'd1);
    drive_beat(64'h5555_8040_5455_4050, 8'ha5, 2'd1);
    random_beats(N_RANGE - 2, 2);

    test_name = "random";
    random_beats(N_RANDOM, -1);

    test_name = "saturate";
    for (int i = 0; i < N_SAT; i++) drive_beat(next_bits(64), 8'hff, 2'd3);
    if (feature_ctr[12] !== 8'hff) begin
      $display("Fail %s feature_ctr[12] expected 255 actual %0d", test_name, feature_ctr[12]);
      errors++;
    end

    test_name = "reload";
    ibc_ctr_reload = 1'b1;
    drive_beat(64'hffff_ffff_ffff_ffff, 8'hff, 2'd3);
    ibc_ctr_reload = 1'b0;
    random_beats(N_RELOAD - 1, -1);

    test_name = "idle";
    drive_beat('0, 8'h00, 2'd0);
    repeat (2) @(negedge clk);

    $display("closing: %0d compare errors, %0d assertion failures",
             errors, u_dut.u_prefix_fe_chk.assert_failures);
    if (errors == 0 && u_dut.u_prefix_fe_chk.assert_failures == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+src
src/prefix_stream_pkg.sv
src/prefix_feature_pkg.sv
src/prefix_char_match.sv
src/prefix_fe_counter.sv
src/prefix_fe.sv
verif/prefix_fe_chk.sv
verif/prefix_fe_tb.sv
